/* src/alu_isa_pkg.sv */
// Opcode and function-code encodings of the integer ALU; referenced by scoped name only
package alu_isa_pkg;

	// ==========================================================
	// Major opcodes
	// ==========================================================
	// TST/CMP/CMPI sit at the base of their 16-code groups
	typedef enum logic [7:0] {
		TST    = 8'h00,
		CMP    = 8'h10,
		CMPI   = 8'h20,
		RR     = 8'h40,	// Register-register, fn selects
		R      = 8'h41,	// Unary, fn selects
		LOGIC  = 8'h42,	// Bitwise two-operand, fn selects
		ADDI   = 8'h48,
		SUBI   = 8'h49,
		MULI   = 8'h4A,
		DIVI   = 8'h4B,
		MULUI  = 8'h4E,
		DIVUI  = 8'h4F,
		ANDI   = 8'h53,
		ORI    = 8'h54,
		EORI   = 8'h55,
		MODI   = 8'h5A,
		MODUI  = 8'h5B,
		ADDU2I = 8'h6B, ADDU4I = 8'h6C, ADDU8I = 8'h6D, ADDU16I = 8'h6E,
		LDI    = 8'h6F,
		MUX    = 8'h72,
		LOOP   = 8'h74
	} op_e;

	// ==========================================================
	// Function codes for RR, R and LOGIC
	// ==========================================================
	typedef enum logic [5:0] {
		// RR group
		ADD = 6'h00, SUB = 6'h01, ADDU = 6'h04, SUBU = 6'h05,
		MUL = 6'h08, MULU = 6'h09, DIV = 6'h0A, DIVU = 6'h0B,
		MOD = 6'h0C, MODU = 6'h0D, MIN = 6'h10, MAX = 6'h11,
		ADDU2 = 6'h14, ADDU4 = 6'h15, ADDU8 = 6'h16, ADDU16 = 6'h17,
		// R group
		MOV = 6'h20, NEG = 6'h21, NOT = 6'h22, ABS = 6'h23,
		SGN = 6'h24, CNTLZ = 6'h25, CNTPOP = 6'h27,
		ZXB = 6'h28, ZXC = 6'h29, ZXH = 6'h2A, COM = 6'h2B,
		SXB = 6'h2C, SXC = 6'h2D, SXH = 6'h2E,
		// LOGIC group
		AND = 6'h30, OR = 6'h31, EOR = 6'h32, NAND = 6'h33,
		NOR = 6'h34, ENOR = 6'h35, ANDC = 6'h36, ORC = 6'h37
	} fn_e;

	// Integer form of TST and CMP; other fn values there are unsupported
	localparam logic [5:0] FN_ICMP = 6'd0;

	// Result of any unsupported op
	localparam logic [63:0] DEAD_WORD = 64'hDEADDEADDEADDEAD;

endpackage

/* src/alu_types_pkg.sv */
// Structured types passed between the ALU modules and the testbench; referenced by scoped name
package alu_types_pkg;

	// One ALU command, opcode in the upper byte
	typedef struct packed {
		logic [7:0] op;
		logic [5:0] fn;
	} alu_cmd_t;

	// ==========================================================
	// Unit steering
	// ==========================================================
	typedef enum logic [1:0] {
		INTOP = 2'd0,	// Single-cycle datapath
		MUL   = 2'd1,
		DIV   = 2'd2
	} unit_e;

	typedef struct packed {
		logic sgn;	// Signed divide
		logic use_imm;	// Divisor from imm instead of b
		logic want_rem;	// Return remainder
	} div_ctl_t;

	// ==========================================================
	// Compare result nybble, replicated across the word
	// ==========================================================
	typedef struct packed {
		logic rsv;	// Always zero
		logic ltu;
		logic lt;
		logic eq;
	} flags_t;

endpackage

/* src/alu_decode.sv */
// Command decode for the ALU; steers loads to the multicycle units and selects result, done, idle
module alu_decode #(
	parameter int DBW = 64
) (
	input  alu_types_pkg::alu_cmd_t cmd,
	input  logic                    ld,
	input  logic [DBW-1:0]          int_o,
	input  logic [DBW-1:0]          mul_o,
	input  logic [DBW-1:0]          div_o,
	input  logic                    mul_done,
	input  logic                    mul_idle,
	input  logic                    div_done,
	input  logic                    div_idle,
	output logic                    mul_ld,
	output logic                    mul_use_imm,
	output logic                    div_ld,
	output alu_types_pkg::div_ctl_t div_ctl,
	output logic [DBW-1:0]          o,
	output logic                    done,
	output logic                    idle
);

	alu_types_pkg::unit_e unit;

	// ==========================================================
	// Classify command
	// ==========================================================
	always_comb
	begin
		unit = alu_types_pkg::INTOP;
		div_ctl = '0;
		mul_use_imm = 1'b0;
		case (cmd.op)
		alu_isa_pkg::RR:
			case (cmd.fn)
			alu_isa_pkg::MUL, alu_isa_pkg::MULU:
				unit = alu_types_pkg::MUL;	// Low word is sign-agnostic
			alu_isa_pkg::DIV, alu_isa_pkg::DIVU, alu_isa_pkg::MOD, alu_isa_pkg::MODU:
			begin
				unit = alu_types_pkg::DIV;
				div_ctl.sgn = cmd.fn == alu_isa_pkg::DIV || cmd.fn == alu_isa_pkg::MOD;
				div_ctl.want_rem = cmd.fn == alu_isa_pkg::MOD || cmd.fn == alu_isa_pkg::MODU;
			end
			default: ;
			endcase
		alu_isa_pkg::MULI, alu_isa_pkg::MULUI:
		begin
			unit = alu_types_pkg::MUL;
			mul_use_imm = 1'b1;
		end
		alu_isa_pkg::DIVI, alu_isa_pkg::DIVUI, alu_isa_pkg::MODI, alu_isa_pkg::MODUI:
		begin
			unit = alu_types_pkg::DIV;
			div_ctl.use_imm = 1'b1;
			div_ctl.sgn = cmd.op == alu_isa_pkg::DIVI || cmd.op == alu_isa_pkg::MODI;
			div_ctl.want_rem = cmd.op == alu_isa_pkg::MODI || cmd.op == alu_isa_pkg::MODUI;
		end
		default: ;
		endcase
	end

	// A busy unit ignores a new load
	assign mul_ld = ld && unit == alu_types_pkg::MUL && mul_idle;
	assign div_ld = ld && unit == alu_types_pkg::DIV && div_idle;

	// ==========================================================
	// Result steering
	// ==========================================================
	always_comb
	begin
		case (unit)
		alu_types_pkg::MUL:
		begin
			o = mul_o;
			done = mul_done;
			idle = mul_idle;
		end
		alu_types_pkg::DIV:
		begin
			o = div_o;
			done = div_done;
			idle = div_idle;
		end
		default:
		begin
			o = int_o;
			done = 1'b1;	// Single-cycle, always ready
			idle = 1'b1;
		end
		endcase
	end

	// A unit reporting done has nothing in flight
	always_comb
	begin
		a_done_idle: assert final (!done || idle)
			else $error("done reported while the selected unit is busy");
	end

endmodule

/* src/alu_intop.sv */
// Single-cycle integer datapath of the ALU; purely combinational from command and operands
module alu_intop #(
	parameter int DBW = 64
) (
	input  alu_types_pkg::alu_cmd_t cmd,
	input  logic [DBW-1:0]          a,
	input  logic [DBW-1:0]          b,
	input  logic [DBW-1:0]          c,
	input  logic [DBW-1:0]          imm,
	output logic [DBW-1:0]          o
);

	localparam int CW = $clog2(DBW + 1);
	localparam logic [DBW-1:0] FILL = alu_isa_pkg::DEAD_WORD[DBW-1:0];

	logic [CW-1:0] clz;
	logic [CW-1:0] pop;

	// Flag nybble for x against y
	function automatic alu_types_pkg::flags_t cmp_flags(input logic [DBW-1:0] x,
		input logic [DBW-1:0] y);
		alu_types_pkg::flags_t f;
		f.rsv = 1'b0;
		f.ltu = x < y;
		f.lt = $signed(x) < $signed(y);
		f.eq = x == y;
		return f;
	endfunction

	// Leading zeros, highest set bit wins
	always_comb
	begin
		clz = CW'(DBW);
		for (int i = 0; i < DBW; i++)
			if (a[i])
				clz = CW'(DBW - 1 - i);
	end

	always_comb
	begin
		pop = '0;
		for (int i = 0; i < DBW; i++)
			pop = pop + CW'(a[i]);
	end

	// ==========================================================
	// Operation select
	// ==========================================================
	always_comb
	begin
		case (cmd.op)
		alu_isa_pkg::LDI:     o = imm;
		alu_isa_pkg::ADDI:    o = a + imm;
		alu_isa_pkg::SUBI:    o = a - imm;
		alu_isa_pkg::ANDI:    o = a & imm;
		alu_isa_pkg::ORI:     o = a | imm;
		alu_isa_pkg::EORI:    o = a ^ imm;
		alu_isa_pkg::ADDU2I:  o = (a << 1) + imm;
		alu_isa_pkg::ADDU4I:  o = (a << 2) + imm;
		alu_isa_pkg::ADDU8I:  o = (a << 3) + imm;
		alu_isa_pkg::ADDU16I: o = (a << 4) + imm;
		alu_isa_pkg::RR:
			case (cmd.fn)
			alu_isa_pkg::ADD, alu_isa_pkg::ADDU: o = a + b;
			alu_isa_pkg::SUB, alu_isa_pkg::SUBU: o = a - b;
			alu_isa_pkg::ADDU2:  o = (a << 1) + b;
			alu_isa_pkg::ADDU4:  o = (a << 2) + b;
			alu_isa_pkg::ADDU8:  o = (a << 3) + b;
			alu_isa_pkg::ADDU16: o = (a << 4) + b;
			alu_isa_pkg::MIN:    o = a < b ? a : b;	// Unsigned compare
			alu_isa_pkg::MAX:    o = a < b ? b : a;
			default:             o = FILL;	// Includes MUL/DIV, steered elsewhere
			endcase
		alu_isa_pkg::R:
			case (cmd.fn)
			alu_isa_pkg::MOV:    o = a;
			alu_isa_pkg::NEG:    o = -a;
			alu_isa_pkg::NOT:    o = DBW'(a == '0);	// Logical not
			alu_isa_pkg::COM:    o = ~a;
			alu_isa_pkg::ABS:    o = a[DBW-1] ? -a : a;
			alu_isa_pkg::SGN:    o = a[DBW-1] ? {DBW{1'b1}} : DBW'(a != '0);
			alu_isa_pkg::CNTLZ:  o = DBW'(clz);
			alu_isa_pkg::CNTPOP: o = DBW'(pop);
			alu_isa_pkg::ZXB:    o = DBW'(a[7:0]);
			alu_isa_pkg::ZXC:    o = DBW'(a[15:0]);
			alu_isa_pkg::ZXH:    o = DBW'(a[31:0]);
			alu_isa_pkg::SXB:    o = DBW'($signed(a[7:0]));
			alu_isa_pkg::SXC:    o = DBW'($signed(a[15:0]));
			alu_isa_pkg::SXH:    o = DBW'($signed(a[31:0]));
			default:             o = FILL;
			endcase
		alu_isa_pkg::LOGIC:
			case (cmd.fn)
			alu_isa_pkg::AND:  o = a & b;
			alu_isa_pkg::ANDC: o = a & ~b;
			alu_isa_pkg::OR:   o = a | b;
			alu_isa_pkg::ORC:  o = a | ~b;
			alu_isa_pkg::EOR:  o = a ^ b;
			alu_isa_pkg::NAND: o = ~(a & b);
			alu_isa_pkg::NOR:  o = ~(a | b);
			alu_isa_pkg::ENOR: o = ~(a ^ b);
			default:           o = FILL;
			endcase
		// TST is a compare against zero
		alu_isa_pkg::TST:
			o = cmd.fn == alu_isa_pkg::FN_ICMP ? {(DBW/4){cmp_flags(a, '0)}} : FILL;
		alu_isa_pkg::CMP:
			o = cmd.fn == alu_isa_pkg::FN_ICMP ? {(DBW/4){cmp_flags(a, b)}} : FILL;
		alu_isa_pkg::CMPI:    o = {(DBW/4){cmp_flags(a, imm)}};
		alu_isa_pkg::MUX:     o = (a & b) | (~a & c);	// Per bit, a picks b
		alu_isa_pkg::LOOP:    o = a != '0 ? a - 1'b1 : a;
		default:              o = FILL;
		endcase
	end

endmodule

/* src/alu_mul.sv */
// Iterative shift-add multiplier of the ALU; one multiplier bit per clock, low word of product
module alu_mul #(
	parameter int DBW = 64
) (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           ld,
	input  logic           abort,
	input  logic           use_imm,
	input  logic [DBW-1:0] a,
	input  logic [DBW-1:0] b,
	input  logic [DBW-1:0] imm,
	output logic [DBW-1:0] o,
	output logic           done,
	output logic           idle
);

	localparam int CW = $clog2(DBW);

	logic [DBW-1:0] mcand;	// Shifts left each step
	logic [DBW-1:0] mplier;	// Shifts right, bit 0 gates the add
	logic [DBW-1:0] acc;
	logic [CW-1:0] cnt;
	logic busy;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy <= 1'b0;
			done <= 1'b1;
			acc <= '0;
			cnt <= '0;
		end
		else if (abort)
		begin
			busy <= 1'b0;
			done <= 1'b0;
		end
		else if (ld)
		begin
			busy <= 1'b1;
			done <= 1'b0;
			acc <= '0;
			cnt <= CW'(DBW - 1);
		end
		else if (busy)
		begin
			acc <= acc + (mplier[0] ? mcand : '0);
			cnt <= cnt - 1'b1;
			if (cnt == '0)
			begin
				busy <= 1'b0;	// Last partial product added this edge
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (ld && !abort)
		begin
			mcand <= a;
			mplier <= use_imm ? imm : b;
		end
		else if (busy)
		begin
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign o = acc;
	assign idle = !busy;

	// Decode must hold off loads while a product is in progress
	a_ld_idle: assert property (@(posedge clk) disable iff (!arst_n) ld |-> idle);

endmodule

/* src/alu_div.sv */
// Iterative restoring divider of the ALU; DBW quotient steps then one sign fixup clock
module alu_div #(
	parameter int DBW = 64
) (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    ld,
	input  logic                    abort,
	input  alu_types_pkg::div_ctl_t ctl,
	input  logic [DBW-1:0]          a,
	input  logic [DBW-1:0]          b,
	input  logic [DBW-1:0]          imm,
	output logic [DBW-1:0]          o,
	output logic                    div_by_zero,
	output logic                    done,
	output logic                    idle
);

	localparam int CW = $clog2(DBW);

	logic [DBW-1:0] q;	// Dividend in, quotient out
	logic [DBW-1:0] r;
	logic [DBW-1:0] dv;	// Divisor magnitude
	logic [CW-1:0] cnt;
	logic busy, fixup;
	logic neg_q, neg_r, want_rem;
	logic [DBW-1:0] dvsr_in, dend_mag, dvsr_mag;
	logic [DBW:0] r_shift, r_trial;

	assign dvsr_in = ctl.use_imm ? imm : b;
	assign dend_mag = (ctl.sgn && a[DBW-1]) ? -a : a;
	assign dvsr_mag = (ctl.sgn && dvsr_in[DBW-1]) ? -dvsr_in : dvsr_in;

	// Top bit of the trial is the borrow
	assign r_shift = {r, q[DBW-1]};
	assign r_trial = r_shift - {1'b0, dv};

	// ==========================================================
	// Control and result registers
	// ==========================================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy <= 1'b0;
			fixup <= 1'b0;
			done <= 1'b1;
			q <= '0;
			r <= '0;
			cnt <= '0;
			div_by_zero <= 1'b0;
			neg_q <= 1'b0;
			neg_r <= 1'b0;
			want_rem <= 1'b0;
		end
		else if (abort)
		begin
			busy <= 1'b0;
			fixup <= 1'b0;
			done <= 1'b0;
		end
		else if (ld)
		begin
			busy <= 1'b1;
			done <= 1'b0;
			q <= dend_mag;
			r <= '0;
			cnt <= CW'(DBW - 1);
			div_by_zero <= dvsr_in == '0;
			// Zero divisor keeps the all-ones quotient unsigned
			neg_q <= ctl.sgn && (a[DBW-1] ^ dvsr_in[DBW-1]) && dvsr_in != '0;
			neg_r <= ctl.sgn && a[DBW-1];	// Remainder follows dividend
			want_rem <= ctl.want_rem;
		end
		else if (busy)
		begin
			if (!r_trial[DBW])
			begin
				r <= r_trial[DBW-1:0];
				q <= {q[DBW-2:0], 1'b1};
			end
			else
			begin
				r <= r_shift[DBW-1:0];	// Restore
				q <= {q[DBW-2:0], 1'b0};
			end
			cnt <= cnt - 1'b1;
			if (cnt == '0)
			begin
				busy <= 1'b0;
				fixup <= 1'b1;
			end
		end
		else if (fixup)
		begin
			fixup <= 1'b0;
			done <= 1'b1;
			if (neg_q)
				q <= -q;
			if (neg_r)
				r <= -r;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ld)
			dv <= dvsr_mag;
	end

	assign o = want_rem ? r : q;
	assign idle = !(busy || fixup);

	a_ld_idle: assert property (@(posedge clk) disable iff (!arst_n) ld |-> idle);
	a_done_busy: assert property (@(posedge clk) disable iff (!arst_n)
		!(done && (busy || fixup)));

endmodule

/* src/thor_alu.sv */
// Integer ALU top level; instantiate with DBW of 64 or 32 and drive with the ld/done handshake
module thor_alu #(
	parameter int DBW = 64
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   ld,
	input  logic                   abort,
	input  alu_types_pkg::alu_cmd_t cmd,
	input  logic [DBW-1:0]         a,
	input  logic [DBW-1:0]         b,
	input  logic [DBW-1:0]         c,
	input  logic [DBW-1:0]         imm,
	output logic [DBW-1:0]         o,
	output logic                   done,
	output logic                   idle,
	output logic                   div_by_zero
);

	logic [DBW-1:0] int_o;
	logic [DBW-1:0] mul_o;
	logic [DBW-1:0] div_o;
	logic mul_ld, mul_done, mul_idle, mul_use_imm;
	logic div_ld, div_done, div_idle;
	alu_types_pkg::div_ctl_t div_ctl;

	alu_decode #(.DBW(DBW)) u_dec (
		.cmd(cmd), .ld(ld),
		.int_o(int_o), .mul_o(mul_o), .div_o(div_o),
		.mul_done(mul_done), .mul_idle(mul_idle),
		.div_done(div_done), .div_idle(div_idle),
		.mul_ld(mul_ld), .mul_use_imm(mul_use_imm),
		.div_ld(div_ld), .div_ctl(div_ctl),
		.o(o), .done(done), .idle(idle)
	);

	alu_intop #(.DBW(DBW)) u_int (
		.cmd(cmd), .a(a), .b(b), .c(c), .imm(imm), .o(int_o)
	);

	alu_mul #(.DBW(DBW)) u_mul (
		.clk(clk), .arst_n(arst_n), .ld(mul_ld), .abort(abort),
		.use_imm(mul_use_imm), .a(a), .b(b), .imm(imm),
		.o(mul_o), .done(mul_done), .idle(mul_idle)
	);

	alu_div #(.DBW(DBW)) u_div (
		.clk(clk), .arst_n(arst_n), .ld(div_ld), .abort(abort),
		.ctl(div_ctl), .a(a), .b(b), .imm(imm),
		.o(div_o), .div_by_zero(div_by_zero),
		.done(div_done), .idle(div_idle)
	);

endmodule

/* test/tb_alu_model.svh */
// Reference model of the ALU, included inside the testbench module once DBW is declared
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// 0 single-cycle, 1 multiplier, 2 divider
function automatic int unit_of(input alu_types_pkg::alu_cmd_t cmd);
	int u;
	u = 0;
	case (cmd.op)
	alu_isa_pkg::MULI, alu_isa_pkg::MULUI: u = 1;
	alu_isa_pkg::DIVI, alu_isa_pkg::DIVUI, alu_isa_pkg::MODI, alu_isa_pkg::MODUI: u = 2;
	alu_isa_pkg::RR:
		if (cmd.fn inside {alu_isa_pkg::MUL, alu_isa_pkg::MULU})
			u = 1;
		else if (cmd.fn inside {alu_isa_pkg::DIV, alu_isa_pkg::DIVU,
			alu_isa_pkg::MOD, alu_isa_pkg::MODU})
			u = 2;
	default: ;
	endcase
	return u;
endfunction

// Flag nybble repeated over the whole word
function automatic logic [DBW-1:0] flag_word(input logic [DBW-1:0] x, input logic [DBW-1:0] y);
	alu_types_pkg::flags_t f;
	logic [DBW-1:0] w;
	f.rsv = 1'b0;
	f.ltu = x < y;
	f.lt = $signed(x) < $signed(y);
	f.eq = x == y;
	for (int i = 0; i < DBW / 4; i++)
		w[i*4 +: 4] = f;
	return w;
endfunction

function automatic logic [DBW-1:0] lead_zeros(input logic [DBW-1:0] x);
	int n;
	n = 0;
	while (n < DBW && !x[DBW-1-n])	// Scan down from the top bit
		n++;
	return DBW'(n);
endfunction

// Low n bits of x, zero or sign filled above
function automatic logic [DBW-1:0] extend(input logic [DBW-1:0] x, input int n, input logic sx);
	logic [DBW-1:0] t;
	t = x << (DBW - n);
	if (sx)
		t = $signed(t) >>> (DBW - n);
	else
		t = t >> (DBW - n);
	return t;
endfunction

// Truncating division, remainder follows the dividend
function automatic logic [DBW-1:0] div_result(input logic [DBW-1:0] x, input logic [DBW-1:0] y,
	input logic sgn, input logic rem, output logic dbz);
	logic [DBW-1:0] mx, my, q, m;
	logic nx, ny;
	nx = sgn && x[DBW-1];
	ny = sgn && y[DBW-1];
	mx = nx ? -x : x;
	my = ny ? -y : y;
	dbz = y == '0;
	if (dbz)
	begin
		q = {DBW{1'b1}};
		m = x;
	end
	else
	begin
		q = mx / my;
		m = mx % my;
		if (nx != ny)
			q = -q;
		if (nx)
			m = -m;
	end
	return rem ? m : q;
endfunction

function automatic logic [DBW-1:0] alu_ref(input alu_types_pkg::alu_cmd_t cmd,
	input logic [DBW-1:0] a, input logic [DBW-1:0] b, input logic [DBW-1:0] c,
	input logic [DBW-1:0] imm, output logic dbz);
	logic [DBW-1:0] r;
	r = alu_isa_pkg::DEAD_WORD[DBW-1:0];
	dbz = 1'b0;
	case (cmd.op)
	alu_isa_pkg::LDI:     r = imm;
	alu_isa_pkg::ADDI:    r = a + imm;
	alu_isa_pkg::SUBI:    r = a - imm;
	alu_isa_pkg::ANDI:    r = a & imm;
	alu_isa_pkg::ORI:     r = a | imm;
	alu_isa_pkg::EORI:    r = a ^ imm;
	alu_isa_pkg::ADDU2I:  r = a * 2 + imm;
	alu_isa_pkg::ADDU4I:  r = a * 4 + imm;
	alu_isa_pkg::ADDU8I:  r = a * 8 + imm;
	alu_isa_pkg::ADDU16I: r = a * 16 + imm;
	alu_isa_pkg::MUX:     r = (b & a) | (c & ~a);
	alu_isa_pkg::LOOP:    r = (a == '0) ? '0 : a - DBW'(1);
	alu_isa_pkg::CMPI:    r = flag_word(a, imm);
	alu_isa_pkg::TST:     if (cmd.fn == 6'd0) r = flag_word(a, '0);
	alu_isa_pkg::CMP:     if (cmd.fn == 6'd0) r = flag_word(a, b);
	alu_isa_pkg::MULI, alu_isa_pkg::MULUI: r = a * imm;	// Low word only
	alu_isa_pkg::DIVI:    r = div_result(a, imm, 1'b1, 1'b0, dbz);
	alu_isa_pkg::DIVUI:   r = div_result(a, imm, 1'b0, 1'b0, dbz);
	alu_isa_pkg::MODI:    r = div_result(a, imm, 1'b1, 1'b1, dbz);
	alu_isa_pkg::MODUI:   r = div_result(a, imm, 1'b0, 1'b1, dbz);
	alu_isa_pkg::RR:
		case (cmd.fn)
		alu_isa_pkg::ADD, alu_isa_pkg::ADDU: r = a + b;
		alu_isa_pkg::SUB, alu_isa_pkg::SUBU: r = a - b;
		alu_isa_pkg::ADDU2:  r = a * 2 + b;
		alu_isa_pkg::ADDU4:  r = a * 4 + b;
		alu_isa_pkg::ADDU8:  r = a * 8 + b;
		alu_isa_pkg::ADDU16: r = a * 16 + b;
		alu_isa_pkg::MIN:    r = (a < b) ? a : b;
		alu_isa_pkg::MAX:    r = (a < b) ? b : a;
		alu_isa_pkg::MUL, alu_isa_pkg::MULU: r = a * b;
		alu_isa_pkg::DIV:    r = div_result(a, b, 1'b1, 1'b0, dbz);
		alu_isa_pkg::DIVU:   r = div_result(a, b, 1'b0, 1'b0, dbz);
		alu_isa_pkg::MOD:    r = div_result(a, b, 1'b1, 1'b1, dbz);
		alu_isa_pkg::MODU:   r = div_result(a, b, 1'b0, 1'b1, dbz);
		default: ;
		endcase
	alu_isa_pkg::R:
		case (cmd.fn)
		alu_isa_pkg::MOV:    r = a;
		alu_isa_pkg::NEG:    r = '0 - a;
		alu_isa_pkg::NOT:    r = (a == '0) ? DBW'(1) : '0;
		alu_isa_pkg::COM:    r = ~a;
		alu_isa_pkg::ABS:    r = ($signed(a) < 0) ? '0 - a : a;
		alu_isa_pkg::SGN:    r = ($signed(a) < 0) ? {DBW{1'b1}} : ((a != '0) ? DBW'(1) : '0);
		alu_isa_pkg::CNTLZ:  r = lead_zeros(a);
		alu_isa_pkg::CNTPOP: r = DBW'($countones(a));
		alu_isa_pkg::ZXB:    r = extend(a, 8, 1'b0);
		alu_isa_pkg::ZXC:    r = extend(a, 16, 1'b0);
		alu_isa_pkg::ZXH:    r = extend(a, 32, 1'b0);
		alu_isa_pkg::SXB:    r = extend(a, 8, 1'b1);
		alu_isa_pkg::SXC:    r = extend(a, 16, 1'b1);
		alu_isa_pkg::SXH:    r = extend(a, 32, 1'b1);
		default: ;
		endcase
	alu_isa_pkg::LOGIC:
		case (cmd.fn)
		alu_isa_pkg::AND:  r = a & b;
		alu_isa_pkg::ANDC: r = a & ~b;
		alu_isa_pkg::OR:   r = a | b;
		alu_isa_pkg::ORC:  r = a | ~b;
		alu_isa_pkg::EOR:  r = a ^ b;
		alu_isa_pkg::NAND: r = ~(a & b);
		alu_isa_pkg::NOR:  r = ~(a | b);
		alu_isa_pkg::ENOR: r = ~(a ^ b);
		default: ;
		endcase
	default: ;
	endcase
	return r;
endfunction

`endif

/* test/tb_thor_alu.sv */
// Testbench of the integer ALU; runs directed and random commands and compares with the model
module tb_thor_alu;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DBW = 64;
	localparam int CLK_NS = 4;
	localparam int N_ROUNDS = 16;
	localparam int OPS_PER_ROUND = 64;
	localparam int N_TESTS = N_ROUNDS * OPS_PER_ROUND + 8;
	localparam int WATCHDOG_NS = N_TESTS * (DBW + 10) * CLK_NS;

	localparam logic [DBW-1:0] CORNER [6] = '{{DBW{1'b0}}, {DBW{1'b1}},
		{1'b1, {(DBW-1){1'b0}}}, DBW'(1), {1'b0, {(DBW-1){1'b1}}}, DBW'(1) << (DBW/2 + 5)};
	localparam logic [5:0] RR_FNS [10] = '{alu_isa_pkg::ADD, alu_isa_pkg::SUB,
		alu_isa_pkg::ADDU, alu_isa_pkg::SUBU, alu_isa_pkg::MIN, alu_isa_pkg::MAX,
		alu_isa_pkg::ADDU2, alu_isa_pkg::ADDU4, alu_isa_pkg::ADDU8, alu_isa_pkg::ADDU16};
	localparam logic [5:0] R_FNS [14] = '{alu_isa_pkg::MOV, alu_isa_pkg::NEG,
		alu_isa_pkg::NOT, alu_isa_pkg::ABS, alu_isa_pkg::SGN, alu_isa_pkg::CNTLZ,
		alu_isa_pkg::CNTPOP, alu_isa_pkg::ZXB, alu_isa_pkg::ZXC, alu_isa_pkg::ZXH,
		alu_isa_pkg::COM, alu_isa_pkg::SXB, alu_isa_pkg::SXC, alu_isa_pkg::SXH};
	localparam logic [5:0] LG_FNS [8] = '{alu_isa_pkg::AND, alu_isa_pkg::OR,
		alu_isa_pkg::EOR, alu_isa_pkg::NAND, alu_isa_pkg::NOR, alu_isa_pkg::ENOR,
		alu_isa_pkg::ANDC, alu_isa_pkg::ORC};
	localparam logic [7:0] IMM_OPS [13] = '{alu_isa_pkg::LDI, alu_isa_pkg::ADDI,
		alu_isa_pkg::SUBI, alu_isa_pkg::ANDI, alu_isa_pkg::ORI, alu_isa_pkg::EORI,
		alu_isa_pkg::ADDU2I, alu_isa_pkg::ADDU4I, alu_isa_pkg::ADDU8I, alu_isa_pkg::ADDU16I,
		alu_isa_pkg::CMPI, alu_isa_pkg::MUX, alu_isa_pkg::LOOP};
	localparam logic [5:0] DIV_FNS [4] = '{alu_isa_pkg::DIV, alu_isa_pkg::DIVU,
		alu_isa_pkg::MOD, alu_isa_pkg::MODU};
	localparam logic [7:0] DIVI_OPS [4] = '{alu_isa_pkg::DIVI, alu_isa_pkg::DIVUI,
		alu_isa_pkg::MODI, alu_isa_pkg::MODUI};

	logic clk, arst_n, ld, abort;
	alu_types_pkg::alu_cmd_t cmd;
	logic [DBW-1:0] a, b, c, imm, o;
	logic done, idle, div_by_zero;

	// Expected result handed to the compare process
	logic [DBW-1:0] exp_o;
	logic exp_dbz, exp_div;
	event check_ev;
	int n_checks = 0;
	int err_val = 0;
	int err_other = 0;

	`include "tb_alu_model.svh"

	thor_alu #(.DBW(DBW)) dut0 (
		.clk(clk), .arst_n(arst_n), .ld(ld), .abort(abort), .cmd(cmd),
		.a(a), .b(b), .c(c), .imm(imm),
		.o(o), .done(done), .idle(idle), .div_by_zero(div_by_zero)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, a unit never reported done", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

	// ==========================================================
	// Compare process
	// ==========================================================
	initial
	begin
		forever
		begin
			@(check_ev);
			n_checks++;
			if (o !== exp_o)
			begin
				err_val++;
				$display("ERR %0t: cmd %h a %h b %h imm %h gave %h, expected %h",
					$time, cmd, a, b, imm, o, exp_o);
			end
			if (exp_div && div_by_zero !== exp_dbz)
			begin
				err_val++;
				$display("ERR %0t: cmd %h b %h imm %h div_by_zero %b, expected %b",
					$time, cmd, b, imm, div_by_zero, exp_dbz);
			end
		end
	end

	function automatic logic [DBW-1:0] rand_word();
		return DBW'({$urandom, $urandom});
	endfunction

	// Load one command, wait for done, then hand over to the compare process
	task automatic run_op(input logic [7:0] op, input logic [5:0] fn, input logic [DBW-1:0] va,
		input logic [DBW-1:0] vb, input logic [DBW-1:0] vc, input logic [DBW-1:0] vimm);
		int unit;
		@(negedge clk);
		cmd.op = op;
		cmd.fn = fn;
		a = va;
		b = vb;
		c = vc;
		imm = vimm;
		unit = unit_of(cmd);
		exp_o = alu_ref(cmd, va, vb, vc, vimm, exp_dbz);
		exp_div = unit == 2;
		ld = 1'b1;
		@(negedge clk);
		ld = 0;
		if (unit != 0 && idle !== 1'b0)
		begin
			err_other++;
			$display("Unit stayed idle after a load of command %h", cmd);
		end
		while (done !== 1'b1)
			@(negedge clk);
		if (idle !== 1'b1)
		begin
			err_other++;
			$display("Unit reported done but not idle for command %h", cmd);
		end
		-> check_ev;
	endtask

	// Status of one multicycle unit after reset, selected through the command
	task automatic check_reset_state(input logic [5:0] fn);
		cmd.op = alu_isa_pkg::RR;
		cmd.fn = fn;
		@(negedge clk);
		if (done !== 1'b1 || idle !== 1'b1 || div_by_zero !== 1'b0 || o !== '0)
		begin
			err_val++;
			$display("ERR %0t: after reset cmd %h done %b idle %b div_by_zero %b o %h",
				$time, cmd, done, idle, div_by_zero, o);
		end
	endtask

	// ==========================================================
	// Stimulus
	// ==========================================================
	initial
	begin
		logic [DBW-1:0] va, vb, vc, vimm;
		void'($urandom(32'he00c));
		arst_n = 1'b0;
		ld = 1'b0;
		abort = 1'b0;
		cmd = '0;
		a = '0;
		b = '0;
		c = '0;
		imm = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		check_reset_state(alu_isa_pkg::MUL);
		check_reset_state(alu_isa_pkg::DIV);

		for (int r = 0; r < N_ROUNDS; r++)
		begin
			if (r < 6)	// Corner values, includes zero divisors
			begin
				va = CORNER[r];
				vb = CORNER[(r + 3) % 6];
				vimm = CORNER[(r + 1) % 6];
			end
			else if (r < 10)
			begin
				va = DBW'(1) << $urandom_range(DBW - 1);	// Single bit
				vb = rand_word();
				vimm = rand_word();
			end
			else
			begin
				va = rand_word();
				vb = rand_word() >> $urandom_range(DBW - 1);
				vimm = rand_word() >> $urandom_range(DBW - 1);
			end
			vc = rand_word();
			foreach (RR_FNS[i])
				run_op(alu_isa_pkg::RR, RR_FNS[i], va, vb, vc, vimm);
			foreach (R_FNS[i])
				run_op(alu_isa_pkg::R, R_FNS[i], va, vb, vc, vimm);
			foreach (LG_FNS[i])
				run_op(alu_isa_pkg::LOGIC, LG_FNS[i], va, vb, vc, vimm);
			foreach (IMM_OPS[i])
				run_op(IMM_OPS[i], 6'd0, va, vb, vc, vimm);
			run_op(alu_isa_pkg::TST, 6'd0, va, vb, vc, vimm);
			run_op(alu_isa_pkg::CMP, 6'd0, va, vb, vc, vimm);
			run_op(alu_isa_pkg::CMP, 6'd0, va, va, vc, vimm);	// Equal case
			run_op(alu_isa_pkg::RR, alu_isa_pkg::MUL, va, vb, vc, vimm);
			run_op(alu_isa_pkg::RR, alu_isa_pkg::MULU, va, vb, vc, vimm);
			run_op(alu_isa_pkg::MULI, 6'd0, va, vb, vc, vimm);
			run_op(alu_isa_pkg::MULUI, 6'd0, va, vb, vc, vimm);
			foreach (DIV_FNS[i])
				run_op(alu_isa_pkg::RR, DIV_FNS[i], va, vb, vc, vimm);
			foreach (DIVI_OPS[i])
				run_op(DIVI_OPS[i], 6'd0, va, vb, vc, vimm);
		end

		// Abort a divide part way through
		@(negedge clk);
		cmd.op = alu_isa_pkg::RR;
		cmd.fn = alu_isa_pkg::DIV;
		a = CORNER[4];
		b = DBW'(3);
		ld = 1'b1;
		@(negedge clk);
		ld = 1'b0;
		repeat (5) @(negedge clk);
		abort = 1'b1;
		@(negedge clk);
		abort = 1'b0;
		if (idle !== 1'b1)
		begin
			err_other++;
			$display("Divider still busy one cycle after abort");
		end
		if (done !== 1'b0)
		begin
			err_other++;
			$display("Divider reports done after abort without a new load");
		end
		run_op(alu_isa_pkg::RR, alu_isa_pkg::DIV, rand_word(), DBW'(7), '0, '0);
		run_op(alu_isa_pkg::MODI, 6'd0, rand_word(), '0, '0, DBW'(11));
		// Unsupported codes
		run_op(8'hFF, 6'd0, rand_word(), rand_word(), '0, '0);
		run_op(alu_isa_pkg::RR, 6'h3F, rand_word(), rand_word(), '0, '0);
		run_op(alu_isa_pkg::CMP, 6'h01, rand_word(), rand_word(), '0, '0);

		@(negedge clk);
		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			n_checks, err_val, err_other);
		if (err_val == 0 && err_other == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* flist.f */
+incdir+test
src/alu_isa_pkg.sv
src/alu_types_pkg.sv
src/alu_decode.sv
src/alu_intop.sv
src/alu_mul.sv
src/alu_div.sv
src/thor_alu.sv
test/tb_thor_alu.sv

/* Makefile */
# Verilator build and run of the ALU testbench

VERILATOR ?= verilator
TOP       ?= tb_thor_alu
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
